// File: project.f
+incdir+testbench
common/priv_pkg.sv
common/csr_if.sv
trap/trap_ctrl.sv
trap/csr_file.sv
design/priv_top.sv
testbench/priv_asserts.sv
testbench/priv_tb.sv

// File: Makefile
# Verilator build and run for the privilege and trap unit testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module priv_tb \
		-f project.f --Mdir $(OBJ_DIR) -o priv_tb_sim

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/priv_tb_sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/priv_tb_tasks.svh
// Directed tests for the privilege and trap unit
// CSR access, M-mode exception, returns and delegation
// Interrupt enables, priority and supervisor interrupts

// ------------------------------
// Plain registers, S views and the pin-driven pending bits
task automatic check_csr_access();
   csr_addr_t plain_regs [6];
   word_t     d;
   plain_regs = '{ADDR_MTVEC, ADDR_MEPC, ADDR_STVEC, ADDR_SEPC, ADDR_MCAUSE, ADDR_SCAUSE};
   foreach (plain_regs[i])
   begin
      d = $urandom;
      write_csr(plain_regs[i], d);
      check_csr(plain_regs[i], d, "plain CSR readback");
   end

   write_csr(ADDR_MSTATUS, word_t'((1 << MPIE) | (3 << MPP)));   // M-only bits set
   d = $urandom;
   write_csr(ADDR_SSTATUS, d);                 // Only S-visible bits stick
   check_csr(ADDR_SSTATUS, d & SSTATUS_MASK, "sstatus view");
   check_csr(ADDR_MSTATUS, word_t'((1 << MPIE) | (3 << MPP)) | (d & SSTATUS_MASK),
             "mstatus after sstatus write");

   write_csr(ADDR_MIE, word_t'((1 << MSI) | (1 << MTI) | (1 << MEI)));   // M-only enables
   d = $urandom;
   write_csr(ADDR_SIE, d);
   check_csr(ADDR_SIE, d & S_INT_MASK, "sie view");
   check_csr(ADDR_MIE, word_t'((1 << MSI) | (1 << MTI) | (1 << MEI)) | (d & S_INT_MASK),
             "mie after sie write");
   write_csr(ADDR_MIE, '0);

   // MEIP and MTIP follow the pins
   write_csr(ADDR_MIP, '0);
   ext_irq = 1'b1;
   check_csr(ADDR_MIP, word_t'(1 << MEI), "mip with ext_irq high");
   ext_irq   = 1'b0;
   timer_irq = 1'b1;
   check_csr(ADDR_MIP, word_t'(1 << MTI), "mip with timer_irq high");
   timer_irq = 1'b0;
   write_csr(ADDR_MIP, word_t'((1 << MEI) | (1 << MTI)));   // Ignored
   check_csr(ADDR_MIP, '0, "mip after write to pin bits");

   write_csr(ADDR_MSTATUS, word_t'(2 << MPP));   // Reserved MPP reads back as U
   check_csr(ADDR_MSTATUS, '0, "mstatus with MPP written as 2");
   write_csr(ADDR_MSTATUS, '0);
endtask

// ------------------------------
// Exception taken in M, vectored mtvec still uses the base
task automatic m_exception();
   word_t pc;
   word_t got_pc;
   word_t st;
   write_csr(ADDR_MTVEC, 32'h0000_2001);
   write_csr(ADDR_MSTATUS, word_t'(1 << MIE));
   pc = $urandom;
   raise_exception(4'd2, pc, got_pc);
   check_word("trap_pc for exception in M", got_pc, 32'h0000_2000);
   check_word("mode after M trap", word_t'(mode), word_t'(M_MODE));
   check_csr(ADDR_MEPC, pc, "mepc");
   check_csr(ADDR_MCAUSE, 32'd2, "mcause");
   read_csr(ADDR_MSTATUS, st);
   check_word("MPP after M trap", word_t'(st[MPP+1:MPP]), word_t'(M_MODE));
   check_word("MPIE after M trap", word_t'(st[MPIE]), 32'd1);   // Old MIE
   check_word("MIE after M trap", word_t'(st[MIE]), 32'd0);
endtask

// ------------------------------
// MRET to U, delegated exception to S, SRET back to U
task automatic return_and_delegation();
   word_t pc;
   word_t got_pc;
   word_t st;
   write_csr(ADDR_MSTATUS, word_t'(1 << SPP));   // MPP = U, SPP set
   pulse_return(1'b0);
   check_word("mode after mret", word_t'(mode), word_t'(U_MODE));

   write_csr(ADDR_MEDELEG, word_t'(1 << 8));   // ECALL from U goes to S
   write_csr(ADDR_STVEC, 32'h0000_3000);
   pc = $urandom;
   raise_exception(4'd8, pc, got_pc);
   check_word("trap_pc for delegated exception", got_pc, 32'h0000_3000);
   check_word("mode after delegated trap", word_t'(mode), word_t'(S_MODE));
   check_csr(ADDR_SEPC, pc, "sepc");
   check_csr(ADDR_SCAUSE, 32'd8, "scause");
   read_csr(ADDR_SSTATUS, st);
   check_word("SPP after trap from U", word_t'(st[SPP]), 32'd0);

   pulse_return(1'b1);
   check_word("mode after sret", word_t'(mode), word_t'(U_MODE));

   // Not delegated, back up to M
   raise_exception(4'd2, pc, got_pc);
   check_word("mode after non-delegated trap", word_t'(mode), word_t'(M_MODE));
   // Delegated cause raised in M stays in M
   raise_exception(4'd8, pc, got_pc);
   check_word("trap_pc for cause 8 in M", got_pc, 32'h0000_2000);
   check_word("mode after cause 8 in M", word_t'(mode), word_t'(M_MODE));
   check_csr(ADDR_MCAUSE, 32'd8, "mcause for cause 8 in M");
endtask

// ------------------------------
// MIE gating and machine interrupt priority
task automatic irq_enable_priority();
   word_t got_pc;
   write_csr(ADDR_MSTATUS, '0);
   write_csr(ADDR_MIE, word_t'((1 << MSI) | (1 << MTI) | (1 << MEI)));
   write_csr(ADDR_MIP, word_t'(1 << MSI));
   timer_irq = 1'b1;
   ext_irq   = 1'b1;
   no_trap_for(3, "trap_taken with MIE clear");

   write_csr(ADDR_MSTATUS, word_t'(1 << MIE));
   wait_trap("software interrupt", got_pc);
   check_word("trap_pc for MSI", got_pc, 32'h0000_2000 + 4 * 3);   // Vectored
   check_csr(ADDR_MCAUSE, 32'h8000_0003, "mcause for MSI");

   write_csr(ADDR_MIP, '0);                    // MSIP off, timer beats external
   write_csr(ADDR_MSTATUS, word_t'(1 << MIE));
   wait_trap("timer interrupt", got_pc);
   check_word("trap_pc for MTI", got_pc, 32'h0000_2000 + 4 * 7);
   check_csr(ADDR_MCAUSE, 32'h8000_0007, "mcause for MTI");
   timer_irq = 1'b0;
   ext_irq   = 1'b0;
   write_csr(ADDR_MIE, '0);
endtask

// ------------------------------
// Delegated SSI across M, U and S
task automatic supervisor_irqs();
   word_t got_pc;
   word_t st;
   write_csr(ADDR_MIDELEG, word_t'(1 << SSI));
   write_csr(ADDR_MIE, word_t'((1 << SSI) | (1 << MTI)));
   write_csr(ADDR_MSTATUS, word_t'((1 << MIE) | (1 << SPP)));   // MPP = U, SIE clear
   write_csr(ADDR_SIP, word_t'(1 << SSI));
   no_trap_for(3, "trap_taken for SSI in M");

   pulse_return(1'b0);
   check_word("mode after mret to U", word_t'(mode), word_t'(U_MODE));
   wait_trap("SSI in U", got_pc);
   check_word("trap_pc for SSI", got_pc, 32'h0000_3000);
   check_word("mode after SSI", word_t'(mode), word_t'(S_MODE));
   check_csr(ADDR_SCAUSE, 32'h8000_0001, "scause for SSI");
   read_csr(ADDR_SSTATUS, st);
   check_word("SPP after SSI from U", word_t'(st[SPP]), 32'd0);

   no_trap_for(3, "trap_taken for SSI in S with SIE clear");
   write_csr(ADDR_MCAUSE, '0);                 // Old MTI cause out of the way
   timer_irq = 1'b1;                           // Not delegated
   wait_trap("timer interrupt in S", got_pc);
   check_word("trap_pc for MTI from S", got_pc, 32'h0000_2000 + 4 * 7);
   check_word("mode after MTI from S", word_t'(mode), word_t'(M_MODE));
   check_csr(ADDR_MCAUSE, 32'h8000_0007, "mcause for MTI from S");
   read_csr(ADDR_MSTATUS, st);
   check_word("MPP after trap from S", word_t'(st[MPP+1:MPP]), word_t'(S_MODE));

   timer_irq = 1'b0;
   write_csr(ADDR_MIP, '0);
   write_csr(ADDR_MIE, '0);
   write_csr(ADDR_MIDELEG, '0);
endtask

// File: testbench/priv_tb.sv
// Testbench for the privilege and trap unit
// Clock, reset, DUT instance and the shared check helpers
// Runs the directed tests and prints the closing status
`timescale 1ns/1ps

module priv_tb;
   import priv_pkg::*;

   logic      clk_in;
   logic      reset_in;
   logic      csr_wr;
   csr_addr_t csr_addr;
   word_t     csr_wdata;
   word_t     csr_rdata;
   logic      exception_flag;
   cause_t    exception_cause;
   word_t     exception_pc;
   logic      mret;
   logic      sret;
   logic      ext_irq;
   logic      timer_irq;
   logic      trap_taken;
   word_t     trap_pc;
   priv_t     mode;

   int        mismatch_count;
   int        timeout_count;

   localparam int TRAP_WAIT = 8;                // Cycles allowed for a trap to show up

   priv_top priv_top_inst (
      .clk_in          (clk_in),
      .reset_in        (reset_in),
      .csr_wr          (csr_wr),
      .csr_addr        (csr_addr),
      .csr_wdata       (csr_wdata),
      .csr_rdata       (csr_rdata),
      .exception_flag  (exception_flag),
      .exception_cause (exception_cause),
      .exception_pc    (exception_pc),
      .mret            (mret),
      .sret            (sret),
      .ext_irq         (ext_irq),
      .timer_irq       (timer_irq),
      .trap_taken      (trap_taken),
      .trap_pc         (trap_pc),
      .mode            (mode)
   );

   always #2 clk_in = ~clk_in;                  // 4 ns period

   // ------------------------------
   // Helpers, all return 1 ns after a rising edge
   task automatic step_cycle();
      @(posedge clk_in);
      #1;
   endtask

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         mismatch_count++;
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic write_csr(input csr_addr_t addr, input word_t data);
      csr_wr    = 1'b1;
      csr_addr  = addr;
      csr_wdata = data;
      step_cycle();                             // Write lands on this edge
      csr_wr    = 1'b0;
   endtask

   task automatic read_csr(input csr_addr_t addr, output word_t data);
      csr_addr = addr;
      #1;                                       // Combinational read settles
      data = csr_rdata;
      step_cycle();
   endtask

   task automatic check_csr(input csr_addr_t addr, input word_t exp, input string what);
      word_t got;
      read_csr(addr, got);
      check_word(what, got, exp);
   endtask

   // Polls trap_taken mid-cycle and grabs the handler address
   task automatic wait_trap(input string what, output word_t pc);
      bit seen;
      int n;
      seen = 1'b0;
      pc   = '0;
      n    = 0;
      while (!seen && n < TRAP_WAIT)
      begin
         #1;
         if (trap_taken)
         begin
            seen = 1'b1;
            pc   = trap_pc;
         end
         step_cycle();                          // Trap taken on this edge
         n++;
      end
      if (!seen)
      begin
         timeout_count++;
         $display("ERROR at %0t: no trap for %s within %0d cycles", $time, what, TRAP_WAIT);
      end
   endtask

   task automatic no_trap_for(input int cycles, input string what);
      for (int i = 0; i < cycles; i++)
      begin
         #1;
         check_word(what, word_t'(trap_taken), '0);
         step_cycle();
      end
   endtask

   task automatic raise_exception(input cause_t cause, input word_t pc, output word_t got_pc);
      exception_flag  = 1'b1;
      exception_cause = cause;
      exception_pc    = pc;
      wait_trap("exception", got_pc);
      exception_flag  = 1'b0;
   endtask

   task automatic pulse_return(input bit use_sret);
      mret = ~use_sret;
      sret = use_sret;
      step_cycle();
      mret = 1'b0;
      sret = 1'b0;
   endtask

   `include "priv_tb_tasks.svh"

   // ------------------------------
   // Test sequence
   initial
   begin
      clk_in          = 1'b0;
      reset_in        = 1'b1;
      csr_wr          = 1'b0;
      csr_addr        = '0;
      csr_wdata       = '0;
      exception_flag  = 1'b0;
      exception_cause = '0;
      exception_pc    = '0;
      mret            = 1'b0;
      sret            = 1'b0;
      ext_irq         = 1'b0;
      timer_irq       = 1'b0;
      mismatch_count  = 0;
      timeout_count   = 0;
      void'($urandom(57));                      // Fixed seed for the data words

      repeat (16) @(posedge clk_in);
      #1;
      reset_in = 1'b0;

      check_word("mode after reset", word_t'(mode), word_t'(M_MODE));
      check_csr(ADDR_MTVEC, RESET_VECTOR, "mtvec after reset");

      check_csr_access();
      m_exception();
      return_and_delegation();
      irq_enable_priority();
      supervisor_irqs();

      $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: testbench/priv_asserts.sv
// Bound checks on the privilege and trap unit
// One event per cycle, legal mode value, aligned handler address
`timescale 1ns/1ps

module priv_asserts
(
   input logic            clk_in,
   input logic            reset_in,
   input logic            trap_taken,
   input logic            mret,
   input logic            sret,
   input priv_pkg::word_t trap_pc,
   input priv_pkg::priv_t mode
);

   // Trap, MRET and SRET never share a cycle
   one_event: assert property (@(posedge clk_in) disable iff (reset_in)
                               $onehot0({trap_taken, mret, sret}))
      else $error("trap, mret and sret active in the same cycle");

   legal_mode: assert property (@(posedge clk_in) disable iff (reset_in)
                                mode != 2'b10)          // 2 is reserved
      else $error("mode holds the reserved value 2");

   aligned_pc: assert property (@(posedge clk_in) disable iff (reset_in)
                                trap_taken |-> (trap_pc[1:0] == 2'b00))
      else $error("trap_pc is not word aligned");

endmodule

bind priv_top priv_asserts priv_asserts_inst (
   .clk_in     (clk_in),
   .reset_in   (reset_in),
   .trap_taken (trap_taken),
   .mret       (mret),
   .sret       (sret),
   .trap_pc    (trap_pc),
   .mode       (mode)
);

// File: design/priv_top.sv
// Top level of the privilege and trap unit
// CSR file and trap controller joined by the CSR interface
`timescale 1ns/1ps

module priv_top
(
   input  logic                clk_in,
   input  logic                reset_in,

   // CSR access port
   input  logic                csr_wr,
   input  priv_pkg::csr_addr_t csr_addr,
   input  priv_pkg::word_t     csr_wdata,
   output priv_pkg::word_t     csr_rdata,

   // Events from the pipeline
   input  logic                exception_flag,
   input  priv_pkg::cause_t    exception_cause,
   input  priv_pkg::word_t     exception_pc,
   input  logic                mret,
   input  logic                sret,

   // Interrupt pins
   input  logic                ext_irq,
   input  logic                timer_irq,

   // Trap result
   output logic                trap_taken,
   output priv_pkg::word_t     trap_pc,
   output priv_pkg::priv_t     mode
);

   csr_if csr_bus ();

   csr_file csr_file_inst (
      .clk_in       (clk_in),
      .reset_in     (reset_in),
      .csr_wr       (csr_wr),
      .csr_addr     (csr_addr),
      .csr_wdata    (csr_wdata),
      .csr_rdata    (csr_rdata),
      .exception_pc (exception_pc),
      .mret         (mret),
      .sret         (sret),
      .ext_irq      (ext_irq),
      .timer_irq    (timer_irq),
      .csr          (csr_bus.csr_side)
   );

   trap_ctrl trap_ctrl_inst (
      .clk_in          (clk_in),
      .reset_in        (reset_in),
      .exception_flag  (exception_flag),
      .exception_cause (exception_cause),
      .mret            (mret),
      .sret            (sret),
      .csr             (csr_bus.trap_side),
      .trap_pc         (trap_pc),
      .mode            (mode)
   );

   assign trap_taken = csr_bus.trap_taken;   // Same-cycle trap decision

endmodule

// File: trap/csr_file.sv
// CSR file for the machine and supervisor registers
// Software read/write port with supervisor views
// Trap, MRET and SRET updates of the status and cause registers
`timescale 1ns/1ps

module csr_file
(
   input  logic                clk_in,
   input  logic                reset_in,

   input  logic                csr_wr,             // Write strobe
   input  priv_pkg::csr_addr_t csr_addr,
   input  priv_pkg::word_t     csr_wdata,
   output priv_pkg::word_t     csr_rdata,          // Same cycle read

   input  priv_pkg::word_t     exception_pc,       // Saved into mepc / sepc on a trap
   input  logic                mret,
   input  logic                sret,
   input  logic                ext_irq,            // MEIP pin
   input  logic                timer_irq,          // MTIP pin

   csr_if.csr_side             csr
);
   import priv_pkg::*;

   // Control state
   word_t mstatus_q, mstatus_n;
   word_t mie_q,     mie_n;
   word_t mip_sw_q,  mip_sw_n;                     // Software pending bits only
   word_t mtvec_q,   mtvec_n;
   word_t stvec_q,   stvec_n;
   word_t medeleg_q, medeleg_n;
   word_t mideleg_q, mideleg_n;

   // Payload
   word_t mepc_q,    mepc_n;
   word_t sepc_q,    sepc_n;
   word_t mcause_q,  mcause_n;
   word_t scause_q,  scause_n;

   word_t mip_view;
   word_t cause_word;

   // Hardware pending bits merged in here
   assign mip_view = mip_sw_q | (word_t'(ext_irq) << MEI) | (word_t'(timer_irq) << MTI);

   assign cause_word = {csr.trap_irq, 27'd0, csr.trap_cause};   // Bit 31 marks interrupts

   // ------------------------------
   // Read port
   always_comb
   begin
      case (csr_addr)
         ADDR_MSTATUS : csr_rdata = mstatus_q;
         ADDR_MIE     : csr_rdata = mie_q;
         ADDR_MIP     : csr_rdata = mip_view;
         ADDR_MTVEC   : csr_rdata = mtvec_q;
         ADDR_MEPC    : csr_rdata = mepc_q;
         ADDR_MCAUSE  : csr_rdata = mcause_q;
         ADDR_MEDELEG : csr_rdata = medeleg_q;
         ADDR_MIDELEG : csr_rdata = mideleg_q;
         ADDR_SSTATUS : csr_rdata = mstatus_q & SSTATUS_MASK;
         ADDR_SIE     : csr_rdata = mie_q & S_INT_MASK;
         ADDR_SIP     : csr_rdata = mip_view & S_INT_MASK;
         ADDR_STVEC   : csr_rdata = stvec_q;
         ADDR_SEPC    : csr_rdata = sepc_q;
         ADDR_SCAUSE  : csr_rdata = scause_q;
         default      : csr_rdata = '0;            // Unknown CSR reads zero
      endcase
   end

   // ------------------------------
   // Next state, software write first
   always_comb
   begin
      mstatus_n = mstatus_q;
      mie_n     = mie_q;
      mip_sw_n  = mip_sw_q;
      mtvec_n   = mtvec_q;
      stvec_n   = stvec_q;
      medeleg_n = medeleg_q;
      mideleg_n = mideleg_q;
      mepc_n    = mepc_q;
      sepc_n    = sepc_q;
      mcause_n  = mcause_q;
      scause_n  = scause_q;

      if (csr_wr)
      begin
         case (csr_addr)
            ADDR_MSTATUS : mstatus_n = csr_wdata & MSTATUS_MASK;
            ADDR_MIE     : mie_n     = csr_wdata & INT_MASK;
            ADDR_MIP     : mip_sw_n  = csr_wdata & MIP_SW_MASK;   // MEIP, MTIP read-only
            ADDR_MTVEC   : mtvec_n   = csr_wdata;
            ADDR_MEPC    : mepc_n    = csr_wdata;
            ADDR_MCAUSE  : mcause_n  = csr_wdata;
            ADDR_MEDELEG : medeleg_n = csr_wdata & DELEG_MASK;
            ADDR_MIDELEG : mideleg_n = csr_wdata & DELEG_MASK;
            // S views touch only their own bits
            ADDR_SSTATUS : mstatus_n = (mstatus_q & ~SSTATUS_MASK) | (csr_wdata & SSTATUS_MASK);
            ADDR_SIE     : mie_n     = (mie_q & ~S_INT_MASK) | (csr_wdata & S_INT_MASK);
            ADDR_SIP     : mip_sw_n  = (mip_sw_q & ~S_INT_MASK) | (csr_wdata & S_INT_MASK);
            ADDR_STVEC   : stvec_n   = csr_wdata;
            ADDR_SEPC    : sepc_n    = csr_wdata;
            ADDR_SCAUSE  : scause_n  = csr_wdata;
            default      : ;                       // Writes to unknown CSRs dropped
         endcase
      end

      // WARL, reserved MPP value 2 becomes U
      if (mstatus_n[MPP+1:MPP] == 2'b10)
         mstatus_n[MPP+1:MPP] = U_MODE;

      // Trap and return updates override the write
      if (csr.trap_taken)
      begin
         if (csr.trap_to_s)
         begin
            sepc_n          = exception_pc;
            scause_n        = cause_word;
            mstatus_n[SPIE] = mstatus_q[SIE];
            mstatus_n[SIE]  = 1'b0;
            mstatus_n[SPP]  = csr.cur_mode[0];     // Only U or S can land here
         end
         else
         begin
            mepc_n                = exception_pc;
            mcause_n              = cause_word;
            mstatus_n[MPIE]       = mstatus_q[MIE];
            mstatus_n[MIE]        = 1'b0;
            mstatus_n[MPP+1:MPP]  = csr.cur_mode;
         end
      end
      else if (mret)
      begin
         mstatus_n[MIE]       = mstatus_q[MPIE];
         mstatus_n[MPIE]      = 1'b1;
         mstatus_n[MPP+1:MPP] = U_MODE;
      end
      else if (sret)
      begin
         mstatus_n[SIE]  = mstatus_q[SPIE];
         mstatus_n[SPIE] = 1'b1;
         mstatus_n[SPP]  = 1'b0;
      end
   end

   // ------------------------------
   // Registers
   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         mstatus_q <= '0;
         mie_q     <= '0;
         mip_sw_q  <= '0;
         mtvec_q   <= RESET_VECTOR;
         stvec_q   <= RESET_VECTOR;
         medeleg_q <= '0;
         mideleg_q <= '0;
      end
      else
      begin
         mstatus_q <= mstatus_n;
         mie_q     <= mie_n;
         mip_sw_q  <= mip_sw_n;
         mtvec_q   <= mtvec_n;
         stvec_q   <= stvec_n;
         medeleg_q <= medeleg_n;
         mideleg_q <= mideleg_n;
      end
   end

   always_ff @(posedge clk_in)
   begin
      mepc_q   <= mepc_n;
      sepc_q   <= sepc_n;
      mcause_q <= mcause_n;
      scause_q <= scause_n;
   end

   // State out to the trap controller
   assign csr.mstatus = mstatus_q;
   assign csr.mie_r   = mie_q;
   assign csr.mip_r   = mip_view;
   assign csr.mtvec   = mtvec_q;
   assign csr.stvec   = stvec_q;
   assign csr.medeleg = medeleg_q;
   assign csr.mideleg = mideleg_q;

endmodule

// File: trap/trap_ctrl.sv
// Trap controller
// Mode register, interrupt qualification and priority
// Delegation to S mode and trap vector computation
`timescale 1ns/1ps

module trap_ctrl
(
   input  logic             clk_in,
   input  logic             reset_in,

   input  logic             exception_flag,     // Exception strobe from the pipeline
   input  priv_pkg::cause_t exception_cause,
   input  logic             mret,
   input  logic             sret,

   csr_if.trap_side         csr,

   output priv_pkg::word_t  trap_pc,            // Handler address
   output priv_pkg::priv_t  mode                // Current privilege mode
);
   import priv_pkg::*;

   word_t  pend;                                // Pending and enabled
   word_t  m_act;                               // Active machine-level interrupts
   word_t  s_act;                               // Active delegated interrupts
   logic   m_glb_en;
   logic   s_glb_en;
   logic   irq_flag;
   cause_t irq_cause;
   logic   deleg_bit;
   logic   to_s;
   word_t  tvec;
   word_t  base;
   priv_t  nxt_mode;

   // Highest priority cause in a set: software, then timer, then external
   function automatic cause_t pick_cause(input word_t act, input int sw_bit,
                                         input int tim_bit, input int ext_bit);
      cause_t c;
      c = '0;
      if (act[sw_bit])
         c = cause_t'(sw_bit);
      else if (act[tim_bit])
         c = cause_t'(tim_bit);
      else if (act[ext_bit])
         c = cause_t'(ext_bit);
      return c;
   endfunction

   // ------------------------------
   // Interrupt qualification
   assign pend = csr.mip_r & csr.mie_r & INT_MASK;

   // Higher modes always enabled, own mode needs xIE, lower modes never
   assign m_glb_en = (mode != M_MODE) | csr.mstatus[MIE];
   assign s_glb_en = (mode == U_MODE) | ((mode == S_MODE) & csr.mstatus[SIE]);

   assign m_act = m_glb_en ? (pend & ~csr.mideleg) : '0;
   assign s_act = s_glb_en ? (pend &  csr.mideleg) : '0;

   assign irq_flag = (|m_act) | (|s_act);

   // Machine level wins over supervisor level
   always_comb
   begin
      if (|m_act)
         irq_cause = pick_cause(m_act, MSI, MTI, MEI);
      else
         irq_cause = pick_cause(s_act, SSI, STI, SEI);
   end

   // ------------------------------
   // Trap decision, exception first
   assign csr.trap_taken = exception_flag | irq_flag;
   assign csr.trap_irq   = ~exception_flag & irq_flag;
   assign csr.trap_cause = exception_flag ? exception_cause : irq_cause;

   // Delegation never lowers the privilege from M
   always_comb
   begin
      if (exception_flag)
         deleg_bit = csr.medeleg[exception_cause];
      else
         deleg_bit = csr.mideleg[irq_cause];
      to_s = deleg_bit & (mode != M_MODE);
   end

   assign csr.trap_to_s = to_s;
   assign csr.cur_mode  = mode;

   // ------------------------------
   // Trap vector
   assign tvec = to_s ? csr.stvec : csr.mtvec;
   assign base = {tvec[31:2], 2'b00};           // Mode bits dropped

   always_comb
   begin
      trap_pc = base;
      if (csr.trap_irq && (tvec[1:0] == 2'b01))  // Vectored, interrupts only
         trap_pc = base + (word_t'(csr.trap_cause) << 2);
   end

   // ------------------------------
   // Next mode and mode register
   always_comb
   begin
      nxt_mode = mode;
      if (csr.trap_taken)
         nxt_mode = to_s ? S_MODE : M_MODE;
      else if (mret)
         nxt_mode = csr.mstatus[MPP+1:MPP];      // Back to MPP
      else if (sret)
         nxt_mode = {1'b0, csr.mstatus[SPP]};    // Back to SPP
   end

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
         mode <= M_MODE;
      else
         mode <= nxt_mode;
   end

endmodule

// File: common/csr_if.sv
// CSR state from the CSR file to the trap controller
// Trap decision and current mode back to the CSR file
`timescale 1ns/1ps

interface csr_if;
   import priv_pkg::*;

   // ------------------------------
   // Driven by csr_file
   word_t  mstatus;
   word_t  mie_r;                     // Interrupt enables
   word_t  mip_r;                     // Pending, pins already merged in
   word_t  mtvec;
   word_t  stvec;
   word_t  medeleg;
   word_t  mideleg;

   // ------------------------------
   // Driven by trap_ctrl
   logic   trap_taken;                // Trap happens this cycle
   logic   trap_to_s;                 // Handled in S mode
   logic   trap_irq;                  // Interrupt, not exception
   cause_t trap_cause;
   priv_t  cur_mode;                  // Saved into MPP / SPP

   modport csr_side (
      output mstatus, mie_r, mip_r, mtvec, stvec, medeleg, mideleg,
      input  trap_taken, trap_to_s, trap_irq, trap_cause, cur_mode
   );

   modport trap_side (
      input  mstatus, mie_r, mip_r, mtvec, stvec, medeleg, mideleg,
      output trap_taken, trap_to_s, trap_irq, trap_cause, cur_mode
   );

endinterface

// File: common/priv_pkg.sv
// Shared types for the privilege and trap unit
// Privilege encodings, CSR addresses, interrupt and status bit positions
// Supervisor view masks and reset vector
package priv_pkg;

   typedef logic [31:0] word_t;       // Data and address word
   typedef logic [11:0] csr_addr_t;   // CSR address
   typedef logic [1:0]  priv_t;       // Privilege level
   typedef logic [3:0]  cause_t;      // Trap cause code

   // ------------------------------
   // Privilege modes
   localparam priv_t U_MODE = 2'd0;
   localparam priv_t S_MODE = 2'd1;
   localparam priv_t M_MODE = 2'd3;

   // ------------------------------
   // CSR addresses
   localparam csr_addr_t ADDR_SSTATUS = 12'h100;
   localparam csr_addr_t ADDR_SIE     = 12'h104;
   localparam csr_addr_t ADDR_STVEC   = 12'h105;
   localparam csr_addr_t ADDR_SEPC    = 12'h141;
   localparam csr_addr_t ADDR_SCAUSE  = 12'h142;
   localparam csr_addr_t ADDR_SIP     = 12'h144;
   localparam csr_addr_t ADDR_MSTATUS = 12'h300;
   localparam csr_addr_t ADDR_MEDELEG = 12'h302;
   localparam csr_addr_t ADDR_MIDELEG = 12'h303;
   localparam csr_addr_t ADDR_MIE     = 12'h304;
   localparam csr_addr_t ADDR_MTVEC   = 12'h305;
   localparam csr_addr_t ADDR_MEPC    = 12'h341;
   localparam csr_addr_t ADDR_MCAUSE  = 12'h342;
   localparam csr_addr_t ADDR_MIP     = 12'h344;

   // ------------------------------
   // Interrupt bit positions in mie / mip, same as the interrupt cause
   localparam int SSI = 1;
   localparam int MSI = 3;
   localparam int STI = 5;
   localparam int MTI = 7;
   localparam int SEI = 9;
   localparam int MEI = 11;

   // Status field positions in mstatus
   localparam int SIE  = 1;
   localparam int MIE  = 3;
   localparam int SPIE = 5;
   localparam int MPIE = 7;
   localparam int SPP  = 8;
   localparam int MPP  = 11;          // Low bit, field is [MPP+1:MPP]

   // ------------------------------
   // Masks
   localparam word_t SSTATUS_MASK = word_t'((1 << SIE) | (1 << SPIE) | (1 << SPP));
   localparam word_t MSTATUS_MASK = SSTATUS_MASK |
                                    word_t'((1 << MIE) | (1 << MPIE) | (3 << MPP));
   localparam word_t S_INT_MASK   = word_t'((1 << SSI) | (1 << STI) | (1 << SEI));
   localparam word_t INT_MASK     = S_INT_MASK | word_t'((1 << MSI) | (1 << MTI) | (1 << MEI));
   localparam word_t MIP_SW_MASK  = S_INT_MASK | word_t'(1 << MSI);  // MEIP, MTIP come from pins
   localparam word_t DELEG_MASK   = 32'h0000_FFFF;                  // Only 16 cause codes

   localparam word_t RESET_VECTOR = 32'h0000_0100;                  // Initial mtvec / stvec

endpackage
